//--- rtl/res_data_pkg.sv
package res_data_pkg;

    localparam int PIXEL_W   = 16;
    localparam int PROD_W    = 2 * PIXEL_W;
    localparam int FRAC_BITS = 8;

    // Q8.8 pixel and coefficient words
    typedef logic signed [PIXEL_W-1:0] pixel_t;
    typedef logic signed [PIXEL_W-1:0] coef_t;

    // Full pixel times coefficient product, Q16.16
    typedef logic signed [PROD_W-1:0] prod_t;

    localparam pixel_t PIXEL_MAX = 16'sh7FFF;
    localparam pixel_t PIXEL_MIN = 16'sh8000;

    // Clamp a wide value into the pixel range
    function automatic pixel_t sat_pixel(prod_t v);
        if (v > prod_t'(PIXEL_MAX)) begin
            return PIXEL_MAX;
        end
        if (v < prod_t'(PIXEL_MIN)) begin
            return PIXEL_MIN;
        end
        return pixel_t'(v);
    endfunction

    function automatic pixel_t relu(pixel_t v);
        return v[PIXEL_W-1] ? '0 : v;
    endfunction

endpackage

//--- rtl/res_ctrl_pkg.sv
package res_ctrl_pkg;

    // Stage control FSM
    //   ST_LOAD  coefficient words are accepted, pixels dropped
    //   ST_RUN   all coefficients loaded, pixels flow
    typedef enum logic {
        ST_LOAD = 1'b0,
        ST_RUN  = 1'b1
    } stage_state_t;

    // Slot of a coefficient inside one block
    // conv block:  0 scale, 1 bias
    // ident block: 0 scale a, 1 bias a, 2 scale b, 3 bias b
    typedef logic [1:0] coef_idx_t;

    localparam coef_idx_t SLOT_SCALE_A = 2'd0;
    localparam coef_idx_t SLOT_BIAS_A  = 2'd1;
    localparam coef_idx_t SLOT_SCALE_B = 2'd2;
    localparam coef_idx_t SLOT_BIAS_B  = 2'd3;

endpackage

//--- rtl/pe_mac.sv
module pe_mac #(
    parameter int RELU_EN = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  res_data_pkg::pixel_t x,
    input  res_data_pkg::coef_t  scale,
    input  res_data_pkg::coef_t  bias,
    output logic                valid_out,
    output res_data_pkg::pixel_t y
);

    import res_data_pkg::*;

    prod_t  product;
    prod_t  scaled;
    prod_t  biased;
    pixel_t sat;
    pixel_t y_next;

    ////////////////////////////////////////////////////////////
    // Scale, bias, saturate
    ////////////////////////////////////////////////////////////
    always_comb begin
        product = prod_t'(x) * prod_t'(scale);
        // Back to Q8.8 alignment, sign preserved
        scaled  = product >>> FRAC_BITS;
        biased  = scaled + prod_t'(bias);
        sat     = sat_pixel(biased);
        y_next  = (RELU_EN != 0) ? relu(sat) : sat;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        y <= y_next;
    end

    // Downstream blocks count on a clean valid once out of reset
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_out)
    );

endmodule

//--- rtl/conv_down_block.sv
module conv_down_block #(
    parameter int IMAGE_WIDTH  = 128,
    parameter int IMAGE_HEIGHT = 128
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_accept,
    input  res_data_pkg::pixel_t    pxl_in,
    input  logic                    coef_we,
    input  res_ctrl_pkg::coef_idx_t coef_idx,
    input  res_data_pkg::coef_t     coef_data,
    output logic                    valid_out,
    output res_data_pkg::pixel_t    pxl_out
);

    import res_data_pkg::*;
    import res_ctrl_pkg::*;

    localparam int COL_W = $clog2(IMAGE_WIDTH);
    localparam int ROW_W = $clog2(IMAGE_HEIGHT);

    coef_t            scale;
    coef_t            bias;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             keep;

    // Coefficient slots
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scale <= '0;
            bias  <= '0;
        end else if (coef_we) begin
            if (coef_idx == SLOT_SCALE_A) begin
                scale <= coef_data;
            end else if (coef_idx == SLOT_BIAS_A) begin
                bias <= coef_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Raster position of the incoming pixel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pxl_accept) begin
            if (col_cnt == COL_W'(IMAGE_WIDTH - 1)) begin
                col_cnt <= '0;
                // Wrap at frame end
                if (row_cnt == ROW_W'(IMAGE_HEIGHT - 1)) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // Stride 2 in both directions
    assign keep = pxl_accept && !col_cnt[0] && !row_cnt[0];

    pe_mac #(
        .RELU_EN(1)
    ) mac0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (keep),
        .x        (pxl_in),
        .scale    (scale),
        .bias     (bias),
        .valid_out(valid_out),
        .y        (pxl_out)
    );

    a_col_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        col_cnt < IMAGE_WIDTH
    );

endmodule

//--- rtl/ident_block.sv
module ident_block (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  res_data_pkg::pixel_t    pxl_in,
    input  logic                    coef_we,
    input  res_ctrl_pkg::coef_idx_t coef_idx,
    input  res_data_pkg::coef_t     coef_data,
    output logic                    valid_out,
    output res_data_pkg::pixel_t    pxl_out
);

    import res_data_pkg::*;
    import res_ctrl_pkg::*;

    coef_t  scale_a;
    coef_t  bias_a;
    coef_t  scale_b;
    coef_t  bias_b;

    logic   valid_a;
    pixel_t pxl_a;
    logic   valid_b;
    pixel_t pxl_b;

    // Skip path matched to the two pe_mac steps
    pixel_t skip_d1;
    pixel_t skip_d2;
    pixel_t sum_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scale_a <= '0;
            bias_a  <= '0;
            scale_b <= '0;
            bias_b  <= '0;
        end else if (coef_we) begin
            case (coef_idx)
                SLOT_SCALE_A: scale_a <= coef_data;
                SLOT_BIAS_A:  bias_a  <= coef_data;
                SLOT_SCALE_B: scale_b <= coef_data;
                SLOT_BIAS_B:  bias_b  <= coef_data;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Residual path
    ////////////////////////////////////////////////////////////
    pe_mac #(
        .RELU_EN(1)
    ) mac_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .x        (pxl_in),
        .scale    (scale_a),
        .bias     (bias_a),
        .valid_out(valid_a),
        .y        (pxl_a)
    );

    // ReLU for this step comes after the skip add below
    pe_mac #(
        .RELU_EN(0)
    ) mac_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_a),
        .x        (pxl_a),
        .scale    (scale_b),
        .bias     (bias_b),
        .valid_out(valid_b),
        .y        (pxl_b)
    );

    always_ff @(posedge clk) begin
        skip_d1 <= pxl_in;
        skip_d2 <= skip_d1;
    end

    ////////////////////////////////////////////////////////////
    // Skip add
    ////////////////////////////////////////////////////////////
    assign sum_next = relu(sat_pixel(prod_t'(pxl_b) + prod_t'(skip_d2)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_b;
        end
    end

    always_ff @(posedge clk) begin
        pxl_out <= sum_next;
    end

endmodule

//--- rtl/stage_ctrl.sv
module stage_ctrl #(
    parameter int IMAGE_WIDTH  = 128,
    parameter int IMAGE_HEIGHT = 128,
    parameter int N_IDENT      = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  logic                    weight_valid,
    input  res_data_pkg::coef_t     weight_data,
    input  logic                    out_valid,
    output logic                    pxl_accept,
    output logic [N_IDENT:0]        coef_we,
    output res_ctrl_pkg::coef_idx_t coef_idx,
    output res_data_pkg::coef_t     coef_data,
    output logic                    weights_ready,
    output logic                    frame_done
);

    import res_ctrl_pkg::*;

    // Two words for the conv block, four per identity block
    localparam int N_WORDS    = 2 + 4 * N_IDENT;
    localparam int CNT_W      = $clog2(N_WORDS);
    localparam int OUT_PIXELS = (IMAGE_WIDTH / 2) * (IMAGE_HEIGHT / 2);
    localparam int OUT_W      = $clog2(OUT_PIXELS + 1);

    stage_state_t     state;
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] rel_cnt;
    logic             load_strobe;
    logic [N_IDENT:0] we_next;
    coef_idx_t        idx_next;
    logic [OUT_W-1:0] out_cnt;

    assign load_strobe   = weight_valid && (state == ST_LOAD);
    assign pxl_accept    = valid_in && (state == ST_RUN);
    assign weights_ready = (state == ST_RUN);

    ////////////////////////////////////////////////////////////
    // Word count to block and slot
    ////////////////////////////////////////////////////////////
    always_comb begin
        we_next  = '0;
        rel_cnt  = '0;
        idx_next = coef_idx_t'(word_cnt);
        if (word_cnt < CNT_W'(2)) begin
            we_next[0] = 1'b1;
        end else begin
            rel_cnt = word_cnt - CNT_W'(2);
            // Low two bits give the slot, the rest the block
            we_next[1 + rel_cnt / 4] = 1'b1;
            idx_next = coef_idx_t'(rel_cnt);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_LOAD;
            word_cnt <= '0;
            coef_we  <= '0;
        end else begin
            coef_we <= load_strobe ? we_next : '0;
            if (load_strobe) begin
                if (word_cnt == CNT_W'(N_WORDS - 1)) begin
                    state <= ST_RUN;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Word and slot ride along with coef_we
    always_ff @(posedge clk) begin
        if (load_strobe) begin
            coef_data <= weight_data;
            coef_idx  <= idx_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output frame count
    ////////////////////////////////////////////////////////////
    assign frame_done = out_valid && (out_cnt == OUT_W'(OUT_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cnt <= '0;
        end else if (out_valid) begin
            out_cnt <= frame_done ? '0 : out_cnt + 1'b1;
        end
    end

    a_we_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(coef_we)
    );

    // Reload needs a reset
    a_no_weight_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(weight_valid && state == ST_RUN)
    );

endmodule

//--- rtl/res_stage_top.sv
module res_stage_top #(
    parameter int IMAGE_WIDTH  = 128,
    parameter int IMAGE_HEIGHT = 128,
    parameter int N_IDENT      = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  res_data_pkg::pixel_t pxl_in,
    input  logic                 weight_valid,
    input  res_data_pkg::coef_t  weight_data,
    output logic                 valid_out,
    output res_data_pkg::pixel_t pxl_out,
    output logic                 weights_ready,
    output logic                 frame_done
);

    import res_data_pkg::*;
    import res_ctrl_pkg::*;

    logic             pxl_accept;
    logic [N_IDENT:0] coef_we;
    coef_idx_t        coef_idx;
    coef_t            coef_data;

    // Stage k feeds stage k+1, index 0 is the conv block output
    logic [N_IDENT:0] chain_vld;
    pixel_t           chain_pxl [0:N_IDENT];

    stage_ctrl #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .N_IDENT     (N_IDENT)
    ) ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .out_valid    (valid_out),
        .pxl_accept   (pxl_accept),
        .coef_we      (coef_we),
        .coef_idx     (coef_idx),
        .coef_data    (coef_data),
        .weights_ready(weights_ready),
        .frame_done   (frame_done)
    );

    conv_down_block #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) conv0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_accept(pxl_accept),
        .pxl_in    (pxl_in),
        .coef_we   (coef_we[0]),
        .coef_idx  (coef_idx),
        .coef_data (coef_data),
        .valid_out (chain_vld[0]),
        .pxl_out   (chain_pxl[0])
    );

    for (genvar k = 0; k < N_IDENT; k++) begin : g_ident
        ident_block idb (
            .clk      (clk),
            .rst_n    (rst_n),
            .valid_in (chain_vld[k]),
            .pxl_in   (chain_pxl[k]),
            .coef_we  (coef_we[k+1]),
            .coef_idx (coef_idx),
            .coef_data(coef_data),
            .valid_out(chain_vld[k+1]),
            .pxl_out  (chain_pxl[k+1])
        );
    end

    assign valid_out = chain_vld[N_IDENT];
    assign pxl_out   = chain_pxl[N_IDENT];

endmodule

//--- verif/res_stage_tb.sv
module res_stage_tb;

    import res_data_pkg::*;

    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 8;
    localparam int N_IDENT      = 3;

    localparam int CLK_PERIOD = 8;
    localparam int N_COEF     = 2 + 4 * N_IDENT;
    localparam int N_PIXEL    = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int N_OUT      = (IMAGE_WIDTH / 2) * (IMAGE_HEIGHT / 2);
    localparam int N_WORDS    = N_COEF + N_PIXEL + N_OUT;
    localparam int LATENCY    = 1 + 3 * N_IDENT;
    localparam int MAX_GAP    = 3;
    // Coefficients plus two frames of pixels
    localparam int WATCHDOG_CYCLES = 20 * (N_COEF + 2 * N_PIXEL) + 200;

    logic   clk;
    logic   rst_n;
    logic   valid_in;
    pixel_t pxl_in;
    logic   weight_valid;
    coef_t  weight_data;
    logic   valid_out;
    pixel_t pxl_out;
    logic   weights_ready;
    logic   frame_done;

    logic [15:0] stim_mem [0:N_WORDS-1];
    time         due_q [$];
    integer      seed;
    int          out_idx;
    int          frames_seen;
    logic        monitor_on;
    logic        out_due;

    res_stage_top #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .N_IDENT     (N_IDENT)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .pxl_in       (pxl_in),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .valid_out    (valid_out),
        .pxl_out      (pxl_out),
        .weights_ready(weights_ready),
        .frame_done   (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic fail_and_stop();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_pixel(string name, pixel_t actual, pixel_t expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            fail_and_stop();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            fail_and_stop();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    // Pixels ride along with the weight words and must be dropped
    task automatic load_coefs();
        for (int i = 0; i < N_COEF; i++) begin
            @(posedge clk);
            weight_valid <= 1'b1;
            weight_data  <= coef_t'(stim_mem[i]);
            valid_in     <= 1'b1;
            pxl_in       <= 16'sh7FFF;
            @(negedge clk);
            check_flag("weights_ready", weights_ready, 1'b0);
        end
        @(posedge clk);
        weight_valid <= 1'b0;
        valid_in     <= 1'b0;
        @(negedge clk);
        check_flag("weights_ready", weights_ready, 1'b1);
    endtask

    task automatic drive_frame(int max_gap);
        int   gap;
        int   row;
        int   col;
        for (int p = 0; p < N_PIXEL; p++) begin
            gap = 0;
            if (max_gap > 0) begin
                gap = $unsigned($random(seed)) % (max_gap + 1);
            end
            repeat (gap) begin
                @(posedge clk);
                valid_in <= 1'b0;
            end
            @(posedge clk);
            valid_in <= 1'b1;
            pxl_in   <= pixel_t'(stim_mem[N_COEF + p]);
            row = p / IMAGE_WIDTH;
            col = p % IMAGE_WIDTH;
            // Kept pixel shows up at the negedge after LATENCY cycles
            if ((row % 2 == 0) && (col % 2 == 0)) begin
                due_q.push_back($time + LATENCY * CLK_PERIOD + CLK_PERIOD / 2);
            end
        end
        @(posedge clk);
        valid_in <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (monitor_on) begin
            out_due = (due_q.size() > 0) && (due_q[0] == $time);
            check_flag("valid_out", valid_out, out_due);
            if (out_due) begin
                void'(due_q.pop_front());
                check_pixel("pxl_out", pxl_out,
                            pixel_t'(stim_mem[N_COEF + N_PIXEL + out_idx]));
                check_flag("frame_done", frame_done, logic'(out_idx == N_OUT - 1));
                if (out_idx == N_OUT - 1) begin
                    out_idx = 0;
                    frames_seen++;
                end else begin
                    out_idx++;
                end
            end else begin
                check_flag("frame_done", frame_done, 1'b0);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the DUT did not finish both frames in %0d cycles", WATCHDOG_CYCLES);
        fail_and_stop();
    end

    initial begin
        seed         = 21148;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        pxl_in       = '0;
        weight_valid = 1'b0;
        weight_data  = '0;
        out_idx      = 0;
        frames_seen  = 0;
        monitor_on   = 1'b0;
        out_due      = 1'b0;
        $readmemh("verif/res_stage_stim.mem", stim_mem);
        if ($isunknown(stim_mem[N_WORDS-1])) begin
            $display("the stimulus file is missing or shorter than %0d words", N_WORDS);
            fail_and_stop();
        end
        repeat (16) @(posedge clk);
        rst_n      <= 1'b1;
        monitor_on <= 1'b1;
        @(negedge clk);
        check_flag("weights_ready", weights_ready, 1'b0);
        check_flag("valid_out", valid_out, 1'b0);
        check_flag("frame_done", frame_done, 1'b0);

        load_coefs();
        // Nothing may come out of the pixels seen during load
        repeat (20) @(posedge clk);

        drive_frame(0);
        wait (frames_seen == 1);
        drive_frame(MAX_GAP);
        wait (frames_seen == 2);
        repeat (4) @(posedge clk);
        @(negedge clk);

        // Ready level holds until the next reset
        if (weights_ready !== 1'b1) begin
            $display("error at %0t: weights_ready is %b, expected %b", $time, weights_ready,
                     1'b1);
            fail_and_stop();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- verif/res_stage_stim.mem
// One Q8.8 hex word per line: 14 coefficients in load order,
// 64 input pixels in raster order, then 16 expected outputs in order
// Conv scale, conv bias, then scale a, bias a, scale b, bias b per identity block
0200
FF00
0100
0000
0080
0000
0040
FFC0
FE00
0000
0100
0000
0100
0100
// Pixels, row 0 to row 7
0100
6C01
0000
6C03
FF00
6C05
00C0
6C07
6C08
6C09
6C0A
6C0B
6C0C
6C0D
6C0E
6C0F
0200
6C11
0400
6C13
5000
6C15
3000
6C17
6C18
6C19
6C1A
6C1B
6C1C
6C1D
6C1E
6C1F
8000
6C21
1000
6C23
0155
6C25
FFFF
6C27
6C28
6C29
6C2A
6C2B
6C2C
6C2D
6C2E
6C2F
0081
6C31
0800
6C33
2000
6C35
0333
6C37
6C38
6C39
6C3A
6C3B
6C3C
6C3D
6C3E
6C3F
// Expected outputs, one per kept pixel
0380
0100
0100
0280
0680
0C80
7FFF
7FFF
0100
3080
0482
0100
0106
1880
6080
0A1A

//--- src.f
rtl/res_data_pkg.sv
rtl/res_ctrl_pkg.sv
rtl/pe_mac.sv
rtl/conv_down_block.sv
rtl/ident_block.sv
rtl/stage_ctrl.sv
rtl/res_stage_top.sv
verif/res_stage_tb.sv

//--- Bender.yml
package:
  name: res_stage

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - rtl/res_data_pkg.sv
      - rtl/res_ctrl_pkg.sv
      - rtl/pe_mac.sv
      - rtl/conv_down_block.sv
      - rtl/ident_block.sv
      - rtl/stage_ctrl.sv
      - rtl/res_stage_top.sv

  - target: test
    files:
      - verif/res_stage_tb.sv

export_include_dirs: []

dependencies: {}
